/* dcache_pkg.sv */
package dcache_pkg;

    // address split: tag | index | byte offset
    localparam int ADDR_W   = 32;
    localparam int DATA_W   = 32;
    localparam int WAYS     = 4;
    localparam int WAY_W    = 2;
    localparam int OFFSET_W = 2;
    localparam int INDEX_W  = 7;
    localparam int SETS     = 128;
    localparam int TAG_W    = ADDR_W - INDEX_W - OFFSET_W; // 23

    // replacement ages
    localparam int AGE_W = 4;
    localparam logic [AGE_W-1:0] AGE_MAX = AGE_W'(15); // counters stop here

    // core access size, same encoding as the core bus
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2
    } size_e;

    // miss handling states
    typedef enum logic [2:0] {
        IDLE    = 3'd0, // serving hits
        WB_ADDR = 3'd1, // dirty victim address phase
        WB_DATA = 3'd2, // wait for write-back done
        RD_ADDR = 3'd3, // refill address phase
        RD_DATA = 3'd4  // wait for refill word
    } ctrl_state_e;

endpackage

/* cache_lookup_if.sv */
interface cache_lookup_if;

    logic [dcache_pkg::INDEX_W-1:0] index;  // from core address
    logic [dcache_pkg::TAG_W-1:0]   tag;
    logic                           hit;
    logic [dcache_pkg::WAY_W-1:0]   hit_way;
    logic                           victim_dirty;
    logic [dcache_pkg::TAG_W-1:0]   victim_tag;
    logic [dcache_pkg::WAY_W-1:0]   victim_way; // from age_replacer

    modport tags (
        input  index, tag, victim_way,
        output hit, hit_way, victim_dirty, victim_tag
    );

    modport ctrl (
        input hit, victim_dirty, victim_tag, victim_way
    );

    modport age (
        input  index, hit_way,
        output victim_way
    );

    modport data (
        input index, hit_way, victim_way
    );

endinterface

/* cache_fill_if.sv */
interface cache_fill_if;

    logic                           fill_en;  // refill word arrives
    logic [dcache_pkg::INDEX_W-1:0] fill_index;
    logic [dcache_pkg::TAG_W-1:0]   fill_tag;
    logic [dcache_pkg::WAY_W-1:0]   fill_way;
    logic [dcache_pkg::DATA_W-1:0]  fill_data;
    logic                           store_en; // accepted write hit
    logic                           touch_en; // any accepted hit

    modport ctrl (
        output fill_en, fill_index, fill_tag, fill_way, fill_data, store_en, touch_en
    );

    modport tags (input fill_en, fill_index, fill_tag, fill_way, store_en);

    modport data (input fill_en, fill_index, fill_way, fill_data, store_en);

    modport age (input fill_en, fill_index, fill_way, touch_en);

endinterface

/* tag_store.sv */
module tag_store (
    input  logic           clk,
    input  logic           rst,
    cache_lookup_if.tags   lookup,
    cache_fill_if.tags     fill
);

    // per set, one bit or one tag per way
    logic [dcache_pkg::WAYS-1:0] valid_q [dcache_pkg::SETS];
    logic [dcache_pkg::WAYS-1:0] dirty_q [dcache_pkg::SETS];
    logic [dcache_pkg::WAYS-1:0][dcache_pkg::TAG_W-1:0] tag_mem [dcache_pkg::SETS];

    logic [dcache_pkg::WAYS-1:0] set_valid;
    logic [dcache_pkg::WAYS-1:0] set_dirty;
    logic [dcache_pkg::WAYS-1:0][dcache_pkg::TAG_W-1:0] set_tags;

    assign set_valid = valid_q[lookup.index];
    assign set_dirty = dirty_q[lookup.index];
    assign set_tags  = tag_mem[lookup.index];

    // four-way compare
    always_comb begin
        lookup.hit     = 1'b0;
        lookup.hit_way = '0;
        // walk down so the lowest matching way is the one left
        for (int w = dcache_pkg::WAYS - 1; w >= 0; w--) begin
            if (set_valid[w] && set_tags[w] == lookup.tag) begin
                lookup.hit     = 1'b1;
                lookup.hit_way = dcache_pkg::WAY_W'(w);
            end
        end
    end

    // what a miss would evict
    assign lookup.victim_dirty = set_dirty[lookup.victim_way];
    assign lookup.victim_tag   = set_tags[lookup.victim_way];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < dcache_pkg::SETS; s++) begin
                valid_q[s] <= '0;
                dirty_q[s] <= '0;
            end
        end else begin
            if (fill.fill_en) begin
                valid_q[fill.fill_index][fill.fill_way] <= 1'b1;
                dirty_q[fill.fill_index][fill.fill_way] <= 1'b0; // fresh from memory
            end
            if (fill.store_en) begin
                dirty_q[lookup.index][lookup.hit_way] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fill.fill_en) begin
            tag_mem[fill.fill_index][fill.fill_way] <= fill.fill_tag;
        end
    end

endmodule

/* data_store.sv */
module data_store (
    input  logic                             clk,
    cache_lookup_if.data                     lookup,
    cache_fill_if.data                       fill,
    input  dcache_pkg::size_e                size,
    input  logic [dcache_pkg::OFFSET_W-1:0]  offset,
    input  logic [dcache_pkg::DATA_W-1:0]    wdata,
    output logic [dcache_pkg::DATA_W-1:0]    rdata,
    output logic [dcache_pkg::DATA_W-1:0]    victim_data
);

    // one word per line
    logic [dcache_pkg::WAYS-1:0][dcache_pkg::DATA_W-1:0] word_mem [dcache_pkg::SETS];

    logic [dcache_pkg::WAYS-1:0][dcache_pkg::DATA_W-1:0] set_words;
    logic [dcache_pkg::DATA_W/8-1:0] byte_mask;
    logic [dcache_pkg::DATA_W-1:0]   merged;

    assign set_words   = word_mem[lookup.index];
    assign rdata       = set_words[lookup.hit_way];
    assign victim_data = set_words[lookup.victim_way]; // for write-back

    // lanes touched by the store
    always_comb begin
        case (size)
            dcache_pkg::SIZE_BYTE: byte_mask = (dcache_pkg::DATA_W/8)'(1) << offset;
            dcache_pkg::SIZE_HALF: byte_mask = offset[1] ? 4'b1100 : 4'b0011;
            default:               byte_mask = '1;
        endcase
    end

    always_comb begin
        for (int b = 0; b < dcache_pkg::DATA_W / 8; b++) begin
            merged[8*b +: 8] = byte_mask[b] ? wdata[8*b +: 8] : rdata[8*b +: 8];
        end
    end

    always_ff @(posedge clk) begin
        if (fill.fill_en) begin
            word_mem[fill.fill_index][fill.fill_way] <= fill.fill_data;
        end else if (fill.store_en) begin
            word_mem[lookup.index][lookup.hit_way] <= merged; // hit line only
        end
    end

endmodule

/* age_replacer.sv */
module age_replacer (
    input  logic        clk,
    input  logic        rst,
    cache_lookup_if.age lookup,
    cache_fill_if.age   fill
);

    logic [dcache_pkg::WAYS-1:0][dcache_pkg::AGE_W-1:0] age_q [dcache_pkg::SETS];
    logic [dcache_pkg::WAY_W-1:0] victim_q [dcache_pkg::SETS];

    logic                           upd_en;
    logic [dcache_pkg::INDEX_W-1:0] upd_set;
    logic [dcache_pkg::WAY_W-1:0]   upd_way;
    logic [dcache_pkg::WAYS-1:0][dcache_pkg::AGE_W-1:0] cur_ages;
    logic [dcache_pkg::WAYS-1:0][dcache_pkg::AGE_W-1:0] new_ages;
    logic [dcache_pkg::AGE_W-1:0]   oldest;
    logic [dcache_pkg::WAY_W-1:0]   new_victim;

    assign lookup.victim_way = victim_q[lookup.index];

    // a fill wins over a touch, they never overlap anyway
    assign upd_en  = fill.fill_en | fill.touch_en;
    assign upd_set = fill.fill_en ? fill.fill_index : lookup.index;
    assign upd_way = fill.fill_en ? fill.fill_way : lookup.hit_way;
    assign cur_ages = age_q[upd_set];

    always_comb begin
        for (int w = 0; w < dcache_pkg::WAYS; w++) begin
            if (dcache_pkg::WAY_W'(w) == upd_way) begin
                new_ages[w] = '0; // just used
            end else if (cur_ages[w] == dcache_pkg::AGE_MAX) begin
                new_ages[w] = cur_ages[w]; // saturate
            end else begin
                new_ages[w] = cur_ages[w] + 1'b1;
            end
        end
    end

    // oldest after the update, strict compare keeps the lowest way on ties
    always_comb begin
        oldest     = new_ages[0];
        new_victim = '0;
        for (int w = 1; w < dcache_pkg::WAYS; w++) begin
            if (new_ages[w] > oldest) begin
                oldest     = new_ages[w];
                new_victim = dcache_pkg::WAY_W'(w);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < dcache_pkg::SETS; s++) begin
                age_q[s]    <= '0;
                victim_q[s] <= '0;
            end
        end else if (upd_en) begin
            age_q[upd_set]    <= new_ages;
            victim_q[upd_set] <= new_victim;
        end
    end

endmodule

/* refill_ctrl.sv */
module refill_ctrl (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            req,
    input  logic                            wr,
    cache_lookup_if.ctrl                    lookup,
    cache_fill_if.ctrl                      fill,
    input  logic [dcache_pkg::DATA_W-1:0]   victim_data,
    input  logic [dcache_pkg::DATA_W-1:0]   rdata_hit,
    input  logic [dcache_pkg::ADDR_W-1:0]   addr,
    output logic [dcache_pkg::DATA_W-1:0]   rdata,
    output logic                            addr_ok,
    output logic                            data_ok,
    output logic                            mem_req,
    output logic                            mem_wr,
    output logic [dcache_pkg::ADDR_W-1:0]   mem_addr,
    output logic [dcache_pkg::DATA_W-1:0]   mem_wdata,
    input  logic [dcache_pkg::DATA_W-1:0]   mem_rdata,
    input  logic                            mem_addr_ok,
    input  logic                            mem_data_ok
);

    dcache_pkg::ctrl_state_e state_q, state_d;

    logic [dcache_pkg::INDEX_W-1:0] index_q; // miss address held for the refill
    logic [dcache_pkg::TAG_W-1:0]   tag_q;
    logic                           hit_ok;
    logic                           miss;
    logic                           in_wb;

    assign hit_ok = (state_q == dcache_pkg::IDLE) && req && lookup.hit;
    assign miss   = (state_q == dcache_pkg::IDLE) && req && !lookup.hit;
    assign in_wb  = (state_q == dcache_pkg::WB_ADDR) || (state_q == dcache_pkg::WB_DATA);

    // core side answers in the lookup cycle
    assign addr_ok = hit_ok;
    assign data_ok = hit_ok;
    assign rdata   = rdata_hit;

    always_comb begin
        state_d = state_q;
        case (state_q)
            dcache_pkg::IDLE: begin
                if (miss) begin
                    state_d = lookup.victim_dirty ? dcache_pkg::WB_ADDR : dcache_pkg::RD_ADDR;
                end
            end
            dcache_pkg::WB_ADDR: if (mem_addr_ok) state_d = dcache_pkg::WB_DATA;
            dcache_pkg::WB_DATA: if (mem_data_ok) state_d = dcache_pkg::RD_ADDR;
            dcache_pkg::RD_ADDR: if (mem_addr_ok) state_d = dcache_pkg::RD_DATA;
            dcache_pkg::RD_DATA: if (mem_data_ok) state_d = dcache_pkg::IDLE;
            default:             state_d = dcache_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= dcache_pkg::IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk) begin
        if (miss) begin
            index_q <= addr[dcache_pkg::OFFSET_W +: dcache_pkg::INDEX_W];
            tag_q   <= addr[dcache_pkg::ADDR_W-1 -: dcache_pkg::TAG_W];
        end
    end

    // request held through the address phase
    assign mem_req = (state_q == dcache_pkg::WB_ADDR) || (state_q == dcache_pkg::RD_ADDR);
    assign mem_wr  = in_wb;
    assign mem_addr = in_wb ? {lookup.victim_tag, index_q, {dcache_pkg::OFFSET_W{1'b0}}}
                            : {tag_q, index_q, {dcache_pkg::OFFSET_W{1'b0}}};
    assign mem_wdata = victim_data;

    assign fill.fill_en    = (state_q == dcache_pkg::RD_DATA) && mem_data_ok;
    assign fill.fill_index = index_q;
    assign fill.fill_tag   = tag_q;
    assign fill.fill_way   = lookup.victim_way; // pointer is stable while a miss runs
    assign fill.fill_data  = mem_rdata;
    assign fill.store_en   = hit_ok && wr;
    assign fill.touch_en   = hit_ok;

endmodule

/* dcache_top.sv */
module dcache_top (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          req,
    input  logic                          wr,
    input  dcache_pkg::size_e             size,
    input  logic [dcache_pkg::ADDR_W-1:0] addr,
    input  logic [dcache_pkg::DATA_W-1:0] wdata,
    output logic [dcache_pkg::DATA_W-1:0] rdata,
    output logic                          addr_ok,
    output logic                          data_ok,
    output logic                          mem_req,
    output logic                          mem_wr,
    output dcache_pkg::size_e             mem_size,
    output logic [dcache_pkg::ADDR_W-1:0] mem_addr,
    output logic [dcache_pkg::DATA_W-1:0] mem_wdata,
    input  logic [dcache_pkg::DATA_W-1:0] mem_rdata,
    input  logic                          mem_addr_ok,
    input  logic                          mem_data_ok
);

    logic [dcache_pkg::DATA_W-1:0] rdata_hit;
    logic [dcache_pkg::DATA_W-1:0] victim_data;

    cache_lookup_if lookup ();
    cache_fill_if   fill ();

    // address split for the lookup
    assign lookup.index = addr[dcache_pkg::OFFSET_W +: dcache_pkg::INDEX_W];
    assign lookup.tag   = addr[dcache_pkg::ADDR_W-1 -: dcache_pkg::TAG_W];

    assign mem_size = dcache_pkg::SIZE_WORD; // lines are one word

    tag_store u_tags (
        .clk    (clk),
        .rst    (rst),
        .lookup (lookup.tags),
        .fill   (fill.tags)
    );

    data_store u_data (
        .clk         (clk),
        .lookup      (lookup.data),
        .fill        (fill.data),
        .size        (size),
        .offset      (addr[dcache_pkg::OFFSET_W-1:0]),
        .wdata       (wdata),
        .rdata       (rdata_hit),
        .victim_data (victim_data)
    );

    age_replacer u_age (
        .clk    (clk),
        .rst    (rst),
        .lookup (lookup.age),
        .fill   (fill.age)
    );

    refill_ctrl u_ctrl (
        .clk         (clk),
        .rst         (rst),
        .req         (req),
        .wr          (wr),
        .lookup      (lookup.ctrl),
        .fill        (fill.ctrl),
        .victim_data (victim_data),
        .rdata_hit   (rdata_hit),
        .addr        (addr),
        .rdata       (rdata),
        .addr_ok     (addr_ok),
        .data_ok     (data_ok),
        .mem_req     (mem_req),
        .mem_wr      (mem_wr),
        .mem_addr    (mem_addr),
        .mem_wdata   (mem_wdata),
        .mem_rdata   (mem_rdata),
        .mem_addr_ok (mem_addr_ok),
        .mem_data_ok (mem_data_ok)
    );

endmodule

/* tb_mem_model.sv */
module tb_mem_model (
    input  logic        clk,
    input  logic        rst,
    input  logic        mem_req,
    input  logic        mem_wr,
    input  logic [31:0] mem_addr,
    input  logic [31:0] mem_wdata,
    output logic [31:0] mem_rdata,
    output logic        mem_addr_ok,
    output logic        mem_data_ok
);

    logic [31:0] words [logic [29:0]]; // written words, the rest follow the fill pattern
    int          read_count;
    int          write_count;
    logic [31:0] last_wr_addr;
    logic [31:0] last_wr_data;

    logic        busy; // address taken, data phase pending
    logic        op_wr;
    logic [31:0] op_addr;
    logic [31:0] op_data;
    int          delay;

    function automatic logic [31:0] peek(input logic [31:0] a);
        if (words.exists(a[31:2])) begin
            return words[a[31:2]];
        end
        return {2'b00, a[31:2]} ^ 32'h5a3c_96e1; // word address xor a fixed key
    endfunction

    initial begin
        mem_rdata    = '0;
        mem_addr_ok  = 1'b0;
        mem_data_ok  = 1'b0;
        read_count   = 0;
        write_count  = 0;
        last_wr_addr = '0;
        last_wr_data = '0;
        busy         = 1'b0;
        delay        = 0;
        forever begin
            @(posedge clk);
            #1;
            mem_addr_ok = 1'b0;
            mem_data_ok = 1'b0;
            if (rst) begin
                busy = 1'b0;
            end else if (busy || mem_req) begin
                if (delay > 0) begin
                    delay--; // random wait, 0 to 3 cycles
                end else if (!busy) begin
                    mem_addr_ok = 1'b1;
                    busy        = 1'b1;
                    op_wr       = mem_wr;
                    op_addr     = mem_addr;
                    op_data     = mem_wdata;
                    delay       = $urandom_range(3, 0);
                end else begin
                    mem_data_ok = 1'b1;
                    busy        = 1'b0;
                    delay       = $urandom_range(3, 0);
                    if (op_wr) begin
                        words[op_addr[31:2]] = op_data;
                        write_count++;
                        last_wr_addr = op_addr;
                        last_wr_data = op_data;
                    end else begin
                        mem_rdata = peek(op_addr);
                        read_count++;
                    end
                end
            end
        end
    end

endmodule

/* tb_dcache.sv */
module tb_dcache;

    logic clk, rst, req, wr, addr_ok, data_ok;
    logic mem_req, mem_wr, mem_addr_ok, mem_data_ok;
    dcache_pkg::size_e size, mem_size;
    logic [31:0] addr, wdata, rdata, mem_addr, mem_wdata, mem_rdata;

    int errors, checks;
    logic [31:0] ref_mem [logic [29:0]]; // words stored so far
    logic [3:0]  model_age [dcache_pkg::WAYS]; // ages of the set under test

    dcache_top dut (.*);
    tb_mem_model mem (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] make_addr(input int tag, input int set, input int off);
        return {tag[dcache_pkg::TAG_W-1:0], set[dcache_pkg::INDEX_W-1:0],
                off[dcache_pkg::OFFSET_W-1:0]};
    endfunction

    function automatic logic [31:0] ref_read(input logic [31:0] a);
        if (ref_mem.exists(a[31:2])) begin
            return ref_mem[a[31:2]];
        end
        return {2'b00, a[31:2]} ^ 32'h5a3c_96e1; // untouched memory
    endfunction

    // byte lanes picked by size and offset
    function automatic void ref_write(input logic [31:0] a, input dcache_pkg::size_e sz,
                                      input logic [31:0] wd);
        logic [31:0] word;
        logic [3:0]  lanes;
        word = ref_read(a);
        if (sz == dcache_pkg::SIZE_WORD) lanes = 4'b1111;
        else if (sz == dcache_pkg::SIZE_HALF) lanes = a[1] ? 4'b1100 : 4'b0011;
        else lanes = 4'b0001 << a[1:0];
        for (int b = 0; b < 4; b++) begin
            if (lanes[b]) word[8*b +: 8] = wd[8*b +: 8];
        end
        ref_mem[a[31:2]] = word;
    endfunction

    function automatic int model_victim();
        int v;
        v = 0;
        for (int w = 1; w < dcache_pkg::WAYS; w++) begin
            if (model_age[w] > model_age[v]) v = w; // ties stay low
        end
        return v;
    endfunction

    function automatic void model_use(input int way);
        for (int w = 0; w < dcache_pkg::WAYS; w++) begin
            if (w == way) model_age[w] = '0;
            else if (model_age[w] != dcache_pkg::AGE_MAX) model_age[w] = model_age[w] + 1'b1;
        end
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("error: %s = %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic finish_test(input string name, input int e0);
        if (errors == e0) $display("test %s: ok", name);
        else $display("test %s: %0d errors", name, errors - e0);
    endtask

    // one core access, held until addr_ok
    task automatic access(input logic w, input dcache_pkg::size_e sz, input logic [31:0] a,
                          input logic [31:0] wd);
        int          cycles;
        logic        done;
        logic        dok;
        logic [31:0] got;
        req    = 1'b1;
        wr     = w;
        size   = sz;
        addr   = a;
        wdata  = wd;
        done   = 1'b0;
        cycles = 0;
        while (!done && cycles < 200) begin
            @(negedge clk);
            done = addr_ok;
            dok  = data_ok;
            got  = rdata;
            cycles++;
        end
        @(posedge clk);
        #1;
        req = 1'b0;
        if (!done) begin
            $display("access to address %h never completed within 200 cycles", a);
            errors++;
        end else begin
            check_value("data_ok", dok, 1'b1);
            check_value("mem_size", mem_size, dcache_pkg::SIZE_WORD);
            if (w) ref_write(a, sz, wd);
            else check_value("rdata", got, ref_read(a));
        end
    endtask

    task automatic test_read_miss();
        int e0, r0;
        e0 = errors;
        r0 = mem.read_count;
        access(1'b0, dcache_pkg::SIZE_WORD, make_addr(1, 5, 0), '0);
        check_value("mem read count", mem.read_count - r0, 1);
        access(1'b0, dcache_pkg::SIZE_WORD, make_addr(1, 5, 0), '0); // now a hit
        check_value("mem read count", mem.read_count - r0, 1);
        finish_test("read miss", e0);
    endtask

    task automatic test_store_merge();
        int e0, r0, w0;
        logic [31:0] a;
        e0 = errors;
        a  = make_addr(2, 9, 0);
        access(1'b0, dcache_pkg::SIZE_WORD, a, '0); // bring the line in
        r0 = mem.read_count;
        w0 = mem.write_count;
        for (int b = 0; b < 4; b++) begin
            access(1'b1, dcache_pkg::SIZE_BYTE, a + b, {4{8'(8'ha0 + b)}});
            access(1'b0, dcache_pkg::SIZE_WORD, a, '0);
        end
        for (int h = 0; h < 4; h += 2) begin
            access(1'b1, dcache_pkg::SIZE_HALF, a + h, h ? 32'h6d5b_1e0f : 32'h7e81_c33c);
            access(1'b0, dcache_pkg::SIZE_WORD, a, '0);
        end
        access(1'b1, dcache_pkg::SIZE_WORD, a, 32'h1357_9bdf);
        access(1'b0, dcache_pkg::SIZE_WORD, a, '0);
        check_value("mem read count", mem.read_count - r0, 0);
        check_value("mem write count", mem.write_count - w0, 0);
        finish_test("store merge", e0);
    endtask

    task automatic test_eviction();
        int e0, w0, r0, v, evicted;
        int way_tag [dcache_pkg::WAYS];
        e0 = errors;
        w0 = mem.write_count;
        for (int t = 10; t < 15; t++) begin
            v          = model_victim();
            evicted    = way_tag[v]; // only the fifth read evicts a real line
            way_tag[v] = t;
            model_use(v); // fill
            model_use(v); // held request hits after the fill
            access(1'b0, dcache_pkg::SIZE_WORD, make_addr(t, 20, 0), '0);
        end
        r0 = mem.read_count;
        access(1'b0, dcache_pkg::SIZE_WORD, make_addr(evicted, 20, 0), '0);
        check_value("mem read count", mem.read_count - r0, 1);
        check_value("mem write count", mem.write_count - w0, 0);
        finish_test("eviction", e0);
    endtask

    task automatic test_write_back();
        int e0, w0;
        logic [31:0] a;
        e0 = errors;
        w0 = mem.write_count;
        a  = make_addr(20, 33, 0);
        access(1'b1, dcache_pkg::SIZE_WORD, a, 32'hcafe_f00d);
        for (int t = 21; t < 25; t++) begin
            access(1'b0, dcache_pkg::SIZE_WORD, make_addr(t, 33, 0), '0);
        end
        check_value("mem write count", mem.write_count - w0, 1);
        check_value("mem last write address", mem.last_wr_addr, a);
        check_value("mem last write data", mem.last_wr_data, 32'hcafe_f00d);
        access(1'b0, dcache_pkg::SIZE_WORD, a, '0); // refilled from memory
        finish_test("write-back", e0);
    endtask

    task automatic test_random();
        int e0, off;
        logic [31:0] a;
        dcache_pkg::size_e sz;
        e0 = errors;
        for (int i = 0; i < 200; i++) begin
            sz  = dcache_pkg::size_e'($urandom_range(2, 0));
            off = (sz == dcache_pkg::SIZE_BYTE) ? $urandom_range(3, 0)
                : (sz == dcache_pkg::SIZE_HALF) ? 2 * $urandom_range(1, 0) : 0;
            a   = make_addr(100 + $urandom_range(7, 0), 40 + $urandom_range(2, 0), off);
            access($urandom_range(1, 0), sz, a, $urandom);
        end
        // read back every line, then push dirty lines out with fresh tags
        for (int t = 100; t < 108; t++) begin
            for (int s = 40; s < 43; s++) access(1'b0, dcache_pkg::SIZE_WORD, make_addr(t, s, 0), '0);
        end
        for (int t = 200; t < 204; t++) begin
            for (int s = 40; s < 43; s++) access(1'b0, dcache_pkg::SIZE_WORD, make_addr(t, s, 0), '0);
        end
        for (int t = 100; t < 108; t++) begin
            for (int s = 40; s < 43; s++) begin
                check_value("mem word", mem.peek(make_addr(t, s, 0)), ref_read(make_addr(t, s, 0)));
            end
        end
        finish_test("random", e0);
    endtask

    initial begin
        void'($urandom(32'h9376));
        rst    = 1'b1;
        req    = 1'b0;
        wr     = 1'b0;
        size   = dcache_pkg::SIZE_WORD;
        addr   = '0;
        wdata  = '0;
        errors = 0;
        checks = 0;
        for (int w = 0; w < dcache_pkg::WAYS; w++) model_age[w] = '0;
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;
        test_read_miss();
        test_store_merge();
        test_eviction();
        test_write_back();
        test_random();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

/* tb.f */
dcache_pkg.sv
cache_lookup_if.sv
cache_fill_if.sv
tag_store.sv
data_store.sv
age_replacer.sv
refill_ctrl.sv
dcache_top.sv
tb_mem_model.sv
tb_dcache.sv

/* Bender.yml */
package:
  name: dcache

sources:
  - dcache_pkg.sv
  - cache_lookup_if.sv
  - cache_fill_if.sv
  - tag_store.sv
  - data_store.sv
  - age_replacer.sv
  - refill_ctrl.sv
  - dcache_top.sv
  - target: simulation
    files:
      - tb_mem_model.sv
      - tb_dcache.sv
